// ==== fp16_compare.sv ====
// ============================
// Combinational compare for fp16 and 16-bit integers
// Subnormals order by their bit pattern
// Opcodes without a compare give all flags clear
// ============================

module fp16_compare
	import fpu16_pkg::*;
(
	input  instruction_t ir,
	input  logic [15:0]  a,
	input  logic [15:0]  b,
	output cmp_result_t  cmp
);

	logic any_nan;
	logic both_zero;
	logic mag_lt;
	logic f_eq;
	logic f_lt;
	logic s_lt;
	logic u_lt;

	always_comb begin
		any_nan   = (&a[14:10] && |a[9:0]) || (&b[14:10] && |b[9:0]);
		// Plus and minus zero compare equal
		both_zero = (a[14:0] == 15'd0) && (b[14:0] == 15'd0);
		mag_lt    = a[14:0] < b[14:0];
		f_eq      = (a == b) || both_zero;
		// Sign-magnitude ordering, a negative magnitude reverses the order
		case ({a[15], b[15]})
			2'b10:   f_lt = !both_zero;
			2'b01:   f_lt = 1'b0;
			2'b00:   f_lt = mag_lt;
			default: f_lt = !mag_lt && (a[14:0] != b[14:0]);
		endcase
		s_lt = $signed(a) < $signed(b);
		u_lt = a < b;

		cmp = '0;
		case (ir.opcode)
			OP_FLT: begin
				// A NaN leaves only the unordered flag
				cmp.unordered = any_nan;
				cmp.eq        = !any_nan && f_eq;
				cmp.lt        = !any_nan && f_lt;
				cmp.le        = !any_nan && (f_lt || f_eq);
			end
			OP_R2: begin
				if (ir.func == FN_CMP || ir.func == FN_CMPU) begin
					cmp.eq = a == b;
					cmp.lt = (ir.func == FN_CMPU) ? u_lt : s_lt;
					cmp.le = cmp.lt || cmp.eq;
				end
			end
			OP_CMPI: begin
				cmp.eq = a == b;
				cmp.lt = s_lt;
				cmp.le = s_lt || cmp.eq;
			end
			default: ;
		endcase
	end

endmodule

// ==== fp16_convert.sv ====
// ============================
// Two-stage fp16 to int16 and int16 to fp16 converter
// Subnormal inputs convert as zero, no exception flags
// Float to integer saturates, a NaN gives 16'h7FFF
// ============================

module fp16_convert
	import fpu16_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] a,
	input  logic [2:0]  rm,
	output logic [15:0] f2i,
	output logic [15:0] i2f
);

	// ============================
	// Stage one, unpack
	// ============================

	logic [15:0] imag;
	logic        s1_sign;
	logic [4:0]  s1_exp;
	logic [10:0] s1_sig;
	logic        s1_nan;
	logic        s1_inf;
	logic [15:0] s1_imag;
	logic [3:0]  s1_lz;
	logic        s1_rne;

	// Count of zeros above the highest set bit
	function automatic logic [3:0] lead_zeros(input logic [15:0] v);
		logic [3:0] n;
		int         k;
		n = 4'd0;
		for (k = 0; k < 16; k++) begin
			if (v[k])
				n = 4'(15 - k);
		end
		return n;
	endfunction

	// Integer view of a, -32768 fits as an unsigned magnitude
	assign imag = a[15] ? (~a + 16'd1) : a;

	always_ff @(posedge clk) begin
		s1_sign <= a[15];
		s1_exp  <= a[14:10];
		// Exponent zero covers both zero and subnormals
		s1_sig  <= (a[14:10] == 5'd0) ? 11'd0 : {1'b1, a[9:0]};
		s1_nan  <= &a[14:10] && |a[9:0];
		s1_inf  <= &a[14:10] && !(|a[9:0]);
		s1_imag <= imag;
		s1_lz   <= lead_zeros(imag);
		s1_rne  <= rm != RM_RTZ;
	end

	// ============================
	// Stage two, align, round, pack
	// ============================

	logic [4:0]  sh;
	logic [26:0] wide;
	logic [10:0] ipart;
	logic        rnd_up;
	logic [15:0] fmag;
	logic [15:0] f2i_d;
	logic [15:0] norm;
	logic        iup;
	logic [11:0] isig_r;
	logic [4:0]  iexp;
	logic [15:0] i2f_d;

	always_comb begin
		// Value is sig * 2^(exp-25), so exp 25 and up needs no rounding
		sh     = (s1_exp >= 5'd25) ? 5'd0 : 5'd25 - s1_exp;
		wide   = {s1_sig, 16'd0} >> sh;
		ipart  = wide[26:16];
		// Guard is the half bit; ties go to the even integer
		rnd_up = s1_rne && wide[15] && ((|wide[14:0]) || ipart[0]);
		if (s1_exp >= 5'd25)
			fmag = 16'(s1_sig) << (s1_exp - 5'd25);
		else
			fmag = 16'(ipart) + 16'(rnd_up);
		if (s1_nan)
			f2i_d = 16'h7FFF;
		else if (s1_inf || s1_exp >= 5'd30)
			f2i_d = s1_sign ? 16'h8000 : 16'h7FFF;
		else
			f2i_d = s1_sign ? (~fmag + 16'd1) : fmag;

		// Integer side: normalize so bit 15 is the hidden one
		norm   = s1_imag << s1_lz;
		iup    = s1_rne && norm[4] && ((|norm[3:0]) || norm[5]);
		isig_r = {1'b0, norm[15:5]} + 12'(iup);
		iexp   = 5'd30 - {1'b0, s1_lz};
		if (s1_imag == 16'd0)
			i2f_d = 16'd0;
		else if (isig_r[11])
			i2f_d = {s1_sign, iexp + 5'd1, 10'd0};
		else
			i2f_d = {s1_sign, iexp, isig_r[9:0]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			f2i <= '0;
			i2f <= '0;
		end else begin
			f2i <= f2i_d;
			i2f <= i2f_d;
		end
	end

	// A known operand must come out known after both stages
	a_known_out: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(a) |-> ##2 !$isunknown({f2i, i2f}))
		else $error("converter output unknown two cycles after a known input");

endmodule

// ==== fpu16.sv ====
// ============================
// fp16 and integer execute unit
// Result o is combinational from the held request
// done rises once the selected path latency has elapsed
// Undefined opcodes and functions give zero
// ============================

module fpu16
	import fpu16_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  fpu_req_t    cur,
	output logic [15:0] o,
	output logic        done
);

	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] c;
	logic [15:0] imm;
	logic [15:0] cmp_b;
	cmp_result_t cmp;
	logic [15:0] f2i_o;
	logic [15:0] i2f_o;
	logic [15:0] sign_o;
	logic [15:0] res;
	logic [1:0]  lat;
	logic [1:0]  cnt;
	logic        run;

	assign a   = cur.a;
	assign b   = cur.b;
	assign c   = cur.c;
	assign imm = cur.i;

	// The immediate compare takes i as its second operand
	assign cmp_b = (cur.ir.opcode == OP_CMPI) ? imm : b;

	fp16_compare u_cmp (
		.ir  (cur.ir),
		.a   (a),
		.b   (cmp_b),
		.cmp (cmp)
	);

	fp16_convert u_cvt (
		.clk (clk),
		.rst (rst),
		.a   (a),
		.rm  (cur.rm),
		.f2i (f2i_o),
		.i2f (i2f_o)
	);

	// Fold the third operand into a two-operand result
	function automatic logic [15:0] combine(input logic [15:0] x, input logic [15:0] y,
		input logic [2:0] sel);
		case (sel)
			3'd0:    return x & y;
			3'd1:    return x | y;
			3'd2:    return x ^ y;
			3'd3:    return x + y;
			default: return 16'd0;
		endcase
	endfunction

	// Zero, subnormal and NaN give 0, everything else gives plus or minus 1.0
	always_comb begin
		if (a[14:10] == 5'd0 || (&a[14:10] && |a[9:0]))
			sign_o = 16'h0000;
		else
			sign_o = a[15] ? 16'hBC00 : 16'h3C00;
	end

	// ============================
	// Decode and result select
	// ============================

	always_comb begin
		res = 16'd0;
		lat = LAT_SIMPLE;
		case (cur.ir.opcode)
			OP_FLT: begin
				case (cur.ir.func)
					FN_FABS:   res = {1'b0, a[14:0]};
					FN_FNEG:   res = {~a[15], a[14:0]};
					FN_FSIGN:  res = sign_o;
					FN_ISNAN:  res = {15'd0, &a[14:10] && |a[9:0]};
					FN_FINITE: res = {15'd0, ~&a[14:10]};
					FN_FTOI: begin
						res = f2i_o;
						lat = LAT_CONVERT;
					end
					FN_ITOF: begin
						res = i2f_o;
						lat = LAT_CONVERT;
					end
					FN_FSEQ:   res = {15'd0, cmp.eq};
					// Unordered operands count as not equal
					FN_FSNE:   res = {15'd0, ~cmp.eq};
					FN_FSLT:   res = {15'd0, cmp.lt};
					FN_FSLE:   res = {15'd0, cmp.le};
					FN_FCMP:   res = cmp;
					FN_SGNJ:   res = {a[15], b[14:0]};
					FN_SGNJN:  res = {~a[15], b[14:0]};
					FN_SGNJX:  res = {a[15] ^ b[15], b[14:0]};
					default:   res = 16'd0;
				endcase
			end
			OP_R2: begin
				case (cur.ir.func)
					FN_ADD:  res = combine(a + b, c, cur.ir.op3);
					// Subtract ignores op3 and always takes c off as well
					FN_SUB:  res = a - b - c;
					FN_AND:  res = combine(a & b, c, cur.ir.op3);
					FN_OR:   res = combine(a | b, c, cur.ir.op3);
					FN_EOR:  res = combine(a ^ b, c, cur.ir.op3);
					FN_NAND: res = combine(~(a & b), c, cur.ir.op3);
					FN_NOR:  res = combine(~(a | b), c, cur.ir.op3);
					FN_CMP,
					FN_CMPU: res = cmp;
					default: res = 16'd0;
				endcase
			end
			OP_ADDI: res = a + imm;
			OP_ANDI: res = a & imm;
			OP_ORI:  res = a | imm;
			OP_EORI: res = a ^ imm;
			OP_CMPI: res = cmp;
			OP_MOV:  res = a;
			default: res = 16'd0;
		endcase
	end

	assign o = res;

	// ============================
	// Latency counter
	// ============================

	// Counter restarts on start and parks at 3, above every path latency
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= 2'd0;
			run <= 1'b0;
		end else if (start) begin
			cnt <= 2'd0;
			run <= 1'b1;
		end else if (cnt != 2'd3) begin
			cnt <= cnt + 2'd1;
		end
	end

	// The start cycle still carries the count of the previous request
	assign done = run && !start && (cnt >= lat);

endmodule

// ==== fpu16_pkg.sv ====
// ============================
// Shared types for the fp16 and integer functional unit
// Opcode and function values are local to this unit, not an ISA standard
// Rounding codes other than RTZ behave as round-to-nearest-even
// ============================

package fpu16_pkg;

	// ============================
	// Instruction encoding
	// ============================

	// Major opcode, undefined values produce a zero result
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_FLT  = 4'd1,
		OP_R2   = 4'd2,
		OP_ADDI = 4'd4,
		OP_ANDI = 4'd5,
		OP_ORI  = 4'd6,
		OP_EORI = 4'd7,
		OP_CMPI = 4'd8,
		OP_MOV  = 4'd9
	} opcode_e;

	// Function field, the low half serves OP_FLT and the high half OP_R2
	typedef enum logic [4:0] {
		FN_FABS   = 5'd0,
		FN_FNEG   = 5'd1,
		FN_FSIGN  = 5'd2,
		FN_ISNAN  = 5'd3,
		FN_FINITE = 5'd4,
		FN_FTOI   = 5'd5,
		FN_ITOF   = 5'd6,
		FN_FSEQ   = 5'd8,
		FN_FSNE   = 5'd9,
		FN_FSLT   = 5'd10,
		FN_FSLE   = 5'd11,
		FN_FCMP   = 5'd12,
		FN_SGNJ   = 5'd13,
		FN_SGNJN  = 5'd14,
		FN_SGNJX  = 5'd15,
		FN_ADD    = 5'd16,
		FN_SUB    = 5'd17,
		FN_AND    = 5'd18,
		FN_OR     = 5'd19,
		FN_EOR    = 5'd20,
		FN_NAND   = 5'd21,
		FN_NOR    = 5'd22,
		FN_CMP    = 5'd24,
		FN_CMPU   = 5'd25
	} func_e;

	// Opcode sits in the low bits, op3 selects how c is folded in
	typedef struct packed {
		logic [3:0] rsvd;
		logic [2:0] op3;
		func_e      func;
		opcode_e    opcode;
	} instruction_t;

	// One complete request as seen by the issue side
	typedef struct packed {
		instruction_t ir;
		logic [2:0]   rm;
		logic [15:0]  a;
		logic [15:0]  b;
		logic [15:0]  c;
		logic [15:0]  t;
		logic [15:0]  i;
		logic         p;
	} fpu_req_t;

	// Compare flags, eq lands in bit 0
	typedef struct packed {
		logic [11:0] rsvd;
		logic        unordered;
		logic        le;
		logic        lt;
		logic        eq;
	} cmp_result_t;

	// ============================
	// Rounding and latency
	// ============================

	localparam logic [2:0] RM_RNE = 3'd0;
	localparam logic [2:0] RM_RTZ = 3'd1;

	// Cycles after start before the path result is final
	localparam logic [1:0] LAT_SIMPLE  = 2'd0;
	localparam logic [1:0] LAT_CONVERT = 2'd2;

endpackage

// ==== fpu16_top.sv ====
// ============================
// Top level of the fp16 functional unit
// One request at a time, no back-pressure
// ============================

module fpu16_top
	import fpu16_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        issue,
	input  fpu_req_t    req,
	output logic        busy,
	output logic [15:0] result,
	output logic        result_valid
);

	fpu_req_t    cur;
	logic        start;
	logic [15:0] fpu_o;
	logic        fpu_done;

	fpu_issue u_issue (
		.clk          (clk),
		.rst          (rst),
		.issue        (issue),
		.req          (req),
		.result_valid (result_valid),
		.cur          (cur),
		.start        (start),
		.busy         (busy)
	);

	fpu16 u_fpu (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.cur   (cur),
		.o     (fpu_o),
		.done  (fpu_done)
	);

	// Predicate and old target come from the held request
	result_writeback u_wb (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.p            (cur.p),
		.t            (cur.t),
		.o            (fpu_o),
		.done         (fpu_done),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// ==== fpu_issue.sv ====
// ============================
// Issue side that holds one request in flight
// An issue pulse while busy is dropped and flagged
// busy stays high until the writeback pulse
// ============================

module fpu_issue
	import fpu16_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     issue,
	input  fpu_req_t req,
	input  logic     result_valid,
	output fpu_req_t cur,
	output logic     start,
	output logic     busy
);

	logic accept;

	// Only an idle unit takes a new request
	assign accept = issue && !busy;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cur   <= '0;
			start <= 1'b0;
			busy  <= 1'b0;
		end else begin
			// start is a single-cycle pulse following the accepted edge
			start <= accept;
			if (accept) begin
				// cur stays frozen until the next accepted issue
				cur  <= req;
				busy <= 1'b1;
			end else if (result_valid) begin
				busy <= 1'b0;
			end
		end
	end

	// The driver must wait for result_valid before issuing again
	a_issue_idle: assert property (@(posedge clk) disable iff (rst) issue |-> !busy)
		else $error("issue arrived while busy, request dropped");

endmodule

// ==== result_writeback.sv ====
// ============================
// Writeback with predicate select
// Captures once per start, on the first cycle done is high
// result_valid is a single-cycle pulse with no hold
// ============================

module result_writeback (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  logic        p,
	input  logic [15:0] t,
	input  logic [15:0] o,
	input  logic        done,
	output logic [15:0] result,
	output logic        result_valid
);

	logic armed;
	logic capture;

	// done may stay high afterwards, armed limits it to one capture
	assign capture = armed && done;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			armed        <= 1'b0;
			result       <= 16'd0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= capture;
			if (start)
				armed <= 1'b1;
			else if (capture)
				armed <= 1'b0;
			// A false predicate writes the old target back unchanged
			if (capture)
				result <= p ? o : t;
		end
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (rst)
		result_valid |=> !result_valid)
		else $error("result_valid high on two consecutive cycles");

endmodule

// ==== tb_fpu16.sv ====
// ============================
// Testbench for the fp16 functional unit
// One request in flight, the next issue waits for result_valid
// Checking is done by the assertions in the checker
// ============================

module tb_fpu16
	import fpu16_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// Request counts per section, they set the cycle limit
	localparam int N_REQ       = 96 + 360 + 144 + 216 + 48 + 12 + 11;
	localparam int CYCLE_LIMIT = 40 * N_REQ + 100;

	logic        clk;
	logic        rst;
	logic        issue;
	fpu_req_t    req;
	fpu_req_t    sent;
	logic        busy;
	logic [15:0] result;
	logic        result_valid;
	int          errors;
	int          seed;
	int          n_sent = 0;
	int          cycles = 0;

	// Zeros, infinities, NaNs, one and the smallest subnormal
	logic [15:0] fp_special [8] = '{16'h0000, 16'h8000, 16'h7C00, 16'hFC00,
		16'h7E00, 16'hFE01, 16'h3C00, 16'h0001};
	// Halfway values, saturation edges and an integer tie
	logic [15:0] cvt_special [12] = '{16'h3800, 16'h3E00, 16'h4100, 16'hC100,
		16'h3D00, 16'hB800, 16'h7800, 16'hF800, 16'h7BFF, 16'h7E00, 16'hFC00, 16'h0801};
	func_e       sign_fn [8] = '{FN_FABS, FN_FNEG, FN_SGNJ, FN_SGNJN, FN_SGNJX,
		FN_ISNAN, FN_FINITE, FN_FSIGN};
	func_e       cmp_fn [5] = '{FN_FSEQ, FN_FSNE, FN_FSLT, FN_FSLE, FN_FCMP};
	func_e       int_fn [9] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_EOR, FN_NAND, FN_NOR,
		FN_CMP, FN_CMPU};
	opcode_e     imm_op [6] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_EORI, OP_CMPI, OP_MOV};
	logic [4:0]  undef_fn [4] = '{5'd7, 5'd16, 5'd0, 5'd23};

	fpu16_top u_dut (
		.clk          (clk),
		.rst          (rst),
		.issue        (issue),
		.req          (req),
		.busy         (busy),
		.result       (result),
		.result_valid (result_valid)
	);

	tb_fpu16_checks u_chk (
		.clk          (clk),
		.rst          (rst),
		.issue        (issue),
		.sent         (sent),
		.busy         (busy),
		.start        (u_dut.start),
		.done         (u_dut.fpu_done),
		.result       (result),
		.result_valid (result_valid),
		.errors       (errors)
	);

	always #20 clk = ~clk;

	// Ends the run if a result never shows up
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d requests sent", cycles, n_sent);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [15:0] rnd16();
		return 16'($random(seed));
	endfunction

	// Random c, t and i, predicate set, round to nearest even
	function automatic fpu_req_t make_req(input opcode_e op, input func_e fn,
		input logic [15:0] a, input logic [15:0] b);
		fpu_req_t r;
		r           = '0;
		r.ir.opcode = op;
		r.ir.func   = fn;
		r.rm        = RM_RNE;
		r.a         = a;
		r.b         = b;
		r.c         = rnd16();
		r.t         = rnd16();
		r.i         = rnd16();
		r.p         = 1'b1;
		return r;
	endfunction

	// Issue for one edge, then wait for the writeback and the busy release
	task automatic send(input fpu_req_t r);
		req   = r;
		sent  = r;
		issue = 1'b1;
		n_sent++;
		@(posedge clk);
		#2;
		issue = 1'b0;
		while (!result_valid) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
	endtask

	initial begin
		fpu_req_t r;
		int       f;
		int       m;
		int       k;
		int       j;
		clk   = 1'b0;
		rst   = 1'b1;
		issue = 1'b0;
		req   = '0;
		sent  = '0;
		seed  = 673;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		@(posedge clk);
		#2;

		// ============================
		// Floating-point operations
		// ============================

		for (f = 0; f < 8; f++) begin
			for (k = 0; k < 12; k++) begin
				r = make_req(OP_FLT, sign_fn[f], (k < 8) ? fp_special[k] : rnd16(),
					(k < 8) ? fp_special[(k + 5) % 8] : rnd16());
				send(r);
			end
		end
		// Every pair of specials, then random pairs with some equal ones
		for (f = 0; f < 5; f++) begin
			for (k = 0; k < 72; k++) begin
				if (k < 64) begin
					r = make_req(OP_FLT, cmp_fn[f], fp_special[k / 8], fp_special[k % 8]);
				end else begin
					r = make_req(OP_FLT, cmp_fn[f], rnd16(), rnd16());
					if (k < 68)
						r.b = r.a;
				end
				send(r);
			end
		end
		// Code 5 for rm checks the fallback to nearest even
		for (f = 0; f < 2; f++) begin
			for (m = 0; m < 3; m++) begin
				for (k = 0; k < 24; k++) begin
					r = make_req(OP_FLT, (f == 0) ? FN_FTOI : FN_ITOF,
						(k < 12) ? cvt_special[k] : rnd16(), 16'd0);
					r.rm = (m == 2) ? 3'd5 : 3'(m);
					send(r);
				end
			end
		end

		// ============================
		// Integer operations
		// ============================

		// Set 0 has the top bit set so signed and unsigned compares differ
		for (f = 0; f < 9; f++) begin
			for (m = 0; m < 8; m++) begin
				for (j = 0; j < 3; j++) begin
					r = make_req(OP_R2, int_fn[f], rnd16(), rnd16());
					r.ir.op3 = 3'(m);
					if (j == 0) begin
						r.a = 16'h8000;
						r.b = 16'h0001;
					end
					if (j == 1)
						r.b = r.a;
					send(r);
				end
			end
		end
		for (f = 0; f < 6; f++) begin
			for (k = 0; k < 8; k++) begin
				r = make_req(imm_op[f], FN_FABS, rnd16(), rnd16());
				if (k == 0) begin
					r.a = 16'h8000;
					r.i = 16'h0001;
				end
				if (k == 1) begin
					r.a = 16'h0001;
					r.i = 16'h8000;
				end
				send(r);
			end
		end

		// ============================
		// Predicate and undefined codes
		// ============================

		for (k = 0; k < 12; k++) begin
			case (k / 4)
				0:       r = make_req(OP_FLT, FN_FABS, rnd16(), rnd16());
				1:       r = make_req(OP_FLT, FN_FTOI, rnd16(), rnd16());
				default: r = make_req(OP_R2, FN_ADD, rnd16(), rnd16());
			endcase
			r.p = 1'b0;
			send(r);
		end
		// Opcodes 3 and 10 to 15, then functions outside their group
		for (k = 0; k < 11; k++) begin
			r = make_req(OP_FLT, FN_FABS, rnd16(), rnd16());
			if (k < 7) begin
				r.ir.opcode = opcode_e'((k == 0) ? 4'd3 : 4'(k + 9));
			end else begin
				r.ir.opcode = (k < 9) ? OP_FLT : OP_R2;
				r.ir.func   = func_e'(undef_fn[k - 7]);
			end
			send(r);
		end

		repeat (4) @(posedge clk);
		$display("%0d requests, %0d errors", n_sent, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== tb_fpu16_checks.sv ====
// ============================
// Checker for the fp16 functional unit
// Reference model covers every operation the unit keeps
// Subnormal inputs convert as zero, compares order them by value
// Infinity is modelled as a large finite magnitude
// ============================

module tb_fpu16_checks
	import fpu16_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        issue,
	input  fpu_req_t    sent,
	input  logic        busy,
	input  logic        start,
	input  logic        done,
	input  logic [15:0] result,
	input  logic        result_valid,
	output int          errors
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] exp_val;

	initial errors = 0;

	// ============================
	// Reference model
	// ============================

	function automatic logic is_nan(input logic [15:0] x);
		return (x[14:10] == 5'h1F) && (x[9:0] != 10'd0);
	endfunction

	function automatic logic is_convert(input fpu_req_t r);
		return r.ir.opcode == OP_FLT && (r.ir.func == FN_FTOI || r.ir.func == FN_ITOF);
	endfunction

	// Exact real value of an fp16 pattern, NaN is handled by the callers
	function automatic real fp_value(input logic [15:0] x);
		real mag;
		int  e;
		e = x[14:10];
		if (e == 31)
			mag = 1.0e9;
		else if (e == 0)
			mag = x[9:0] / 1024.0 * 2.0 ** -14;
		else
			mag = (1.0 + x[9:0] / 1024.0) * 2.0 ** (e - 15);
		return x[15] ? -mag : mag;
	endfunction

	// Round in the real domain, then saturate to the int16 range
	function automatic logic [15:0] ref_f2i(input logic [15:0] x, input logic [2:0] rm);
		real v;
		real fl;
		real r;
		if (is_nan(x))
			return 16'h7FFF;
		v  = fp_value(x);
		fl = $floor(v);
		if (rm == RM_RTZ) begin
			r = (v < 0.0) ? -$floor(-v) : fl;
		end else begin
			r = fl;
			// Halfway goes to the even neighbour
			if ((v - fl > 0.5) || (v - fl == 0.5 && $rtoi(fl) % 2 != 0))
				r = fl + 1.0;
		end
		if (r > 32767.0)
			return 16'h7FFF;
		if (r < -32768.0)
			return 16'h8000;
		return 16'($rtoi(r));
	endfunction

	// Keep the top 11 bits of the magnitude, round the rest away
	function automatic logic [15:0] ref_i2f(input logic [15:0] x, input logic [2:0] rm);
		int m;
		int k;
		int sh;
		int q;
		int rem;
		m = x[15] ? 65536 - int'(x) : int'(x);
		if (m == 0)
			return 16'd0;
		k = 15;
		while (m < (1 << k))
			k--;
		if (k <= 10) begin
			q = m << (10 - k);
		end else begin
			sh  = k - 10;
			q   = m >> sh;
			rem = m - (q << sh);
			if (rm != RM_RTZ && (rem > (1 << (sh - 1)) || (rem == (1 << (sh - 1)) && q % 2 == 1)))
				q++;
			// A carry out of the significand bumps the exponent
			if (q == 2048) begin
				q = 1024;
				k++;
			end
		end
		return {x[15], 5'(k + 15), q[9:0]};
	endfunction

	// Flags as {unordered, le, lt, eq} in the low nibble
	function automatic logic [15:0] ref_cmp(input instruction_t ir, input logic [15:0] x,
		input logic [15:0] y);
		logic [15:0] f;
		f = 16'd0;
		if (ir.opcode == OP_FLT) begin
			if (is_nan(x) || is_nan(y)) begin
				f[3] = 1'b1;
			end else begin
				f[0] = fp_value(x) == fp_value(y);
				f[1] = fp_value(x) < fp_value(y);
				f[2] = fp_value(x) <= fp_value(y);
			end
		end else if (ir.opcode == OP_CMPI || (ir.opcode == OP_R2 && ir.func == FN_CMP)) begin
			f[0] = x == y;
			f[1] = $signed(x) < $signed(y);
			f[2] = $signed(x) <= $signed(y);
		end else if (ir.opcode == OP_R2 && ir.func == FN_CMPU) begin
			f[0] = x == y;
			f[1] = x < y;
			f[2] = x <= y;
		end
		return f;
	endfunction

	function automatic logic [15:0] ref_combine(input logic [15:0] x, input logic [15:0] y,
		input logic [2:0] sel);
		case (sel)
			3'd0:    return x & y;
			3'd1:    return x | y;
			3'd2:    return x ^ y;
			3'd3:    return x + y;
			default: return 16'd0;
		endcase
	endfunction

	function automatic logic [15:0] ref_result(input fpu_req_t r);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] f;
		logic [15:0] v;
		a = r.a;
		b = r.b;
		f = ref_cmp(r.ir, a, (r.ir.opcode == OP_CMPI) ? r.i : b);
		v = 16'd0;
		if (r.ir.opcode == OP_FLT) begin
			case (r.ir.func)
				FN_FABS:   v = a & 16'h7FFF;
				FN_FNEG:   v = a ^ 16'h8000;
				FN_FSIGN:  v = (is_nan(a) || a[14:10] == 5'd0) ? 16'h0000 :
					(a[15] ? 16'hBC00 : 16'h3C00);
				FN_ISNAN:  v = 16'(is_nan(a));
				FN_FINITE: v = 16'(a[14:10] != 5'h1F);
				FN_FTOI:   v = ref_f2i(a, r.rm);
				FN_ITOF:   v = ref_i2f(a, r.rm);
				FN_FSEQ:   v = 16'(f[0]);
				FN_FSNE:   v = 16'(!f[0]);
				FN_FSLT:   v = 16'(f[1]);
				FN_FSLE:   v = 16'(f[2]);
				FN_FCMP:   v = f;
				FN_SGNJ:   v = (b & 16'h7FFF) | (a & 16'h8000);
				FN_SGNJN:  v = (b & 16'h7FFF) | (~a & 16'h8000);
				FN_SGNJX:  v = (b & 16'h7FFF) | ((a ^ b) & 16'h8000);
				default:   v = 16'd0;
			endcase
		end else if (r.ir.opcode == OP_R2) begin
			case (r.ir.func)
				FN_ADD:  v = ref_combine(a + b, r.c, r.ir.op3);
				FN_SUB:  v = a - b - r.c;
				FN_AND:  v = ref_combine(a & b, r.c, r.ir.op3);
				FN_OR:   v = ref_combine(a | b, r.c, r.ir.op3);
				FN_EOR:  v = ref_combine(a ^ b, r.c, r.ir.op3);
				FN_NAND: v = ref_combine(~(a & b), r.c, r.ir.op3);
				FN_NOR:  v = ref_combine(~(a | b), r.c, r.ir.op3);
				FN_CMP:  v = f;
				FN_CMPU: v = f;
				default: v = 16'd0;
			endcase
		end else begin
			case (r.ir.opcode)
				OP_ADDI: v = a + r.i;
				OP_ANDI: v = a & r.i;
				OP_ORI:  v = a | r.i;
				OP_EORI: v = a ^ r.i;
				OP_CMPI: v = f;
				OP_MOV:  v = a;
				default: v = 16'd0;
			endcase
		end
		// The predicate keeps the old target when clear
		return r.p ? v : r.t;
	endfunction

	always_comb exp_val = ref_result(sent);

	// ============================
	// Assertions
	// ============================

	a_result: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> result == exp_val)
		else begin
			errors++;
			$display("FAILED result: expected %h actual %h (ir %h)",
				$sampled(exp_val), $sampled(result), $sampled(sent.ir));
		end

	// Simple paths land after E+2, conversions after E+4
	a_simple_latency: assert property (@(posedge clk) disable iff (rst)
		(issue && !busy && !is_convert(sent)) |=> !result_valid [*2] ##1 result_valid)
		else begin
			errors++;
			$display("result_valid did not follow a simple issue after two edges");
		end

	a_convert_latency: assert property (@(posedge clk) disable iff (rst)
		(issue && !busy && is_convert(sent)) |=> !result_valid [*4] ##1 result_valid)
		else begin
			errors++;
			$display("result_valid did not follow a conversion issue after four edges");
		end

	a_busy_held: assert property (@(posedge clk) disable iff (rst)
		(issue && !busy) |=> (busy throughout result_valid [->1]))
		else begin
			errors++;
			$display("busy dropped between issue and result_valid");
		end

	// A pulse outside a busy window, or a second one, is a stray writeback
	a_one_pulse: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> busy ##1 (!busy && !result_valid))
		else begin
			errors++;
			$display("result_valid came outside its request or busy stayed high after it");
		end

	a_reset_low: assert property (@(posedge clk)
		rst |-> !busy && !start && !done && !result_valid && result == 16'd0)
		else begin
			errors++;
			$display("control outputs not low while reset is held");
		end

	a_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> !busy && !start && !done && !result_valid && result == 16'd0)
		else begin
			errors++;
			$display("control outputs not low on the first edge after reset");
		end

endmodule

// ==== vlog.f ====
fpu16_pkg.sv
fpu_issue.sv
fp16_compare.sv
fp16_convert.sv
fpu16.sv
result_writeback.sv
fpu16_top.sv
tb_fpu16_checks.sv
tb_fpu16.sv
